/* hw/input_port.sv */
`timescale 1ns/1ps
`default_nettype none

module input_port #(
    parameter int port_no    = 2,
    parameter int fifo_depth = 8
) (
    input  wire                          clk_user,
    input  wire                          reset_user,
    // network side
    input  wire input_port_pkg::packet_t din_leaf,
    input  wire input_port_pkg::leaf_t   src_leaf,
    input  wire input_port_pkg::port_t   src_port,
    output logic                         freespace_update,
    output input_port_pkg::packet_t      freespace_packet,
    // user side
    output input_port_pkg::user_word_t   dout_user,
    output logic                         vld_user,
    input  wire                          ack_user,
    // stats
    input  wire                          done_mode,
    output input_port_pkg::count_t       full_cnt,
    output input_port_pkg::count_t       empty_cnt,
    output input_port_pkg::count_t       read_cnt,
    output logic                         stall
);
    import input_port_pkg::*;

    logic       wr_en;
    slot_addr_t wr_addr;
    payload_t   wr_payload;
    logic       wr_en_even, wr_en_odd;
    bank_addr_t rd_addr;
    logic       clr_even, clr_odd;
    logic       rd_flag_even, rd_flag_odd;
    payload_t   rd_payload_even, rd_payload_odd;
    logic       push;
    payload_t   push_payload;
    logic       fifo_full, fifo_empty;

    //////////////////////////////////////////////////////////////////////
    // credit packet, constant apart from our own leaf and port
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        freespace_packet                           = '0;  // unused and addr zero
        freespace_packet[VALID_POS]                = 1'b1;
        freespace_packet[LEAF_LSB +: LEAF_BITS]    = src_leaf;
        freespace_packet[PORT_LSB +: PORT_BITS]    = src_port;
        freespace_packet[PAYLOAD_BITS-1:0]         = payload_t'(1);  // one slot freed
    end

    packet_decoder #(.port_no(port_no)) i_packet_decoder (
        .clk_user, .reset_user, .din_leaf, .wr_en, .wr_addr, .wr_payload
    );

    // even slots to bank 0, odd slots to bank 1
    assign wr_en_even = wr_en && !wr_addr[0];
    assign wr_en_odd  = wr_en && wr_addr[0];

    reorder_bank bank_even (
        .clk_user, .reset_user,
        .wr_en(wr_en_even), .wr_addr(wr_addr[ADDR_BITS-1:1]), .wr_payload,
        .rd_addr, .clr_en(clr_even),
        .rd_flag(rd_flag_even), .rd_payload(rd_payload_even)
    );

    reorder_bank bank_odd (
        .clk_user, .reset_user,
        .wr_en(wr_en_odd), .wr_addr(wr_addr[ADDR_BITS-1:1]), .wr_payload,
        .rd_addr, .clr_en(clr_odd),
        .rd_flag(rd_flag_odd), .rd_payload(rd_payload_odd)
    );

    read_sequencer i_read_sequencer (
        .clk_user, .reset_user,
        .rd_flag_even, .rd_flag_odd, .rd_payload_even, .rd_payload_odd, .fifo_full,
        .rd_addr, .clr_even, .clr_odd, .push, .push_payload, .freespace_update
    );

    width_converter #(.fifo_depth(fifo_depth)) i_width_converter (
        .clk_user, .reset_user, .push, .push_payload, .ack_user,
        .fifo_full, .fifo_empty, .dout_user, .vld_user
    );

    port_counters i_port_counters (
        .clk_user, .reset_user, .done_mode, .fifo_full, .fifo_empty, .vld_user, .ack_user,
        .full_cnt, .empty_cnt, .read_cnt, .stall
    );

endmodule

`default_nettype wire

/* hw/input_port_pkg.sv */
`default_nettype none

package input_port_pkg;

    //////////////////////////////////////////////////////////////////////
    // packet field widths
    //////////////////////////////////////////////////////////////////////
    localparam int PACKET_BITS    = 97;
    localparam int PAYLOAD_BITS   = 64;
    localparam int LEAF_BITS      = 6;
    localparam int PORT_BITS      = 4;
    localparam int ADDR_BITS      = 7;
    localparam int BANK_ADDR_BITS = ADDR_BITS - 1;  // lsb picks the bank
    localparam int USER_BITS      = 32;

    // field positions, msb down
    localparam int VALID_POS = PACKET_BITS - 1;       // 96
    localparam int LEAF_LSB  = VALID_POS - LEAF_BITS; // 95..90
    localparam int PORT_LSB  = LEAF_LSB - PORT_BITS;  // 89..86
    localparam int ADDR_LSB  = PAYLOAD_BITS;          // 70..64, 85..71 unused

    //////////////////////////////////////////////////////////////////////
    // vector types
    //////////////////////////////////////////////////////////////////////
    typedef logic [PACKET_BITS-1:0]    packet_t;
    typedef logic [PAYLOAD_BITS-1:0]   payload_t;
    typedef logic [ADDR_BITS-1:0]      slot_addr_t;
    typedef logic [BANK_ADDR_BITS-1:0] bank_addr_t;
    typedef logic [LEAF_BITS-1:0]      leaf_t;
    typedef logic [PORT_BITS-1:0]      port_t;
    typedef logic [USER_BITS-1:0]      user_word_t;
    typedef logic [31:0]               count_t;      // stats counters

    // drain sequencer, read then look at the flag
    typedef enum logic {
        seq_issue,
        seq_check
    } seq_state_t;

endpackage

`default_nettype wire

/* hw/packet_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_decoder #(
    parameter int port_no = 2              // this port's number
) (
    input  wire                          clk_user,
    input  wire                          reset_user,
    input  wire input_port_pkg::packet_t din_leaf,   // raw packet from the tree
    output logic                         wr_en,
    output input_port_pkg::slot_addr_t   wr_addr,
    output input_port_pkg::payload_t     wr_payload
);
    import input_port_pkg::*;

    logic       pkt_vld;
    port_t      pkt_port;
    slot_addr_t pkt_addr;
    payload_t   pkt_payload;
    logic       pkt_hit;

    // field split
    assign pkt_vld     = din_leaf[VALID_POS];
    assign pkt_port    = din_leaf[PORT_LSB +: PORT_BITS];
    assign pkt_addr    = din_leaf[ADDR_LSB +: ADDR_BITS];
    assign pkt_payload = din_leaf[PAYLOAD_BITS-1:0];

    // accept only valid packets for this port, leaf already routed by the tree
    assign pkt_hit = pkt_vld && (pkt_port == port_t'(port_no));

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= pkt_hit;               // one cycle after arrival
        end
    end

    // address and payload ride along, only meaningful with wr_en
    always_ff @(posedge clk_user) begin
        if (pkt_hit) begin
            wr_addr    <= pkt_addr;
            wr_payload <= pkt_payload;
        end
    end

endmodule

`default_nettype wire

/* hw/port_counters.sv */
`timescale 1ns/1ps
`default_nettype none

module port_counters (
    input  wire                      clk_user,
    input  wire                      reset_user,
    input  wire                      done_mode,   // freezes the stats
    input  wire                      fifo_full,
    input  wire                      fifo_empty,
    input  wire                      vld_user,
    input  wire                      ack_user,
    output input_port_pkg::count_t   full_cnt,
    output input_port_pkg::count_t   empty_cnt,
    output input_port_pkg::count_t   read_cnt,
    output logic                     stall
);
    import input_port_pkg::*;

    logic counting;

    assign counting = !done_mode;

    // user wants data but the queue has none
    assign stall = counting && ack_user && fifo_empty;

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            full_cnt  <= '0;
            empty_cnt <= '0;
            read_cnt  <= '0;
        end else if (counting) begin
            if (fifo_full)            full_cnt  <= full_cnt + 1'b1;   // cycles full
            if (fifo_empty)           empty_cnt <= empty_cnt + 1'b1;  // cycles empty
            if (vld_user && ack_user) read_cnt  <= read_cnt + 1'b1;   // words taken
        end
    end

endmodule

`default_nettype wire

/* hw/read_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module read_sequencer (
    input  wire                             clk_user,
    input  wire                             reset_user,
    // bank read data, one cycle after rd_addr
    input  wire                             rd_flag_even,
    input  wire                             rd_flag_odd,
    input  wire input_port_pkg::payload_t   rd_payload_even,
    input  wire input_port_pkg::payload_t   rd_payload_odd,
    input  wire                             fifo_full,
    // bank drain port
    output input_port_pkg::bank_addr_t      rd_addr,
    output logic                            clr_even,
    output logic                            clr_odd,
    // to the payload FIFO
    output logic                            push,
    output input_port_pkg::payload_t        push_payload,
    output logic                            freespace_update  // one credit back
);
    import input_port_pkg::*;

    seq_state_t state;
    slot_addr_t drain_ptr;      // next slot in address order
    logic       sel_odd;        // bank of the current slot
    logic       sel_flag;
    logic       drain;

    //////////////////////////////////////////////////////////////////////
    // slot select
    //////////////////////////////////////////////////////////////////////
    assign sel_odd  = drain_ptr[0];
    assign rd_addr  = drain_ptr[ADDR_BITS-1:1];   // same row in both banks
    assign sel_flag = sel_odd ? rd_flag_odd : rd_flag_even;

    assign push_payload = sel_odd ? rd_payload_odd : rd_payload_even;

    // drain only a filled slot and only with room downstream
    assign drain = (state == seq_check) && sel_flag && !fifo_full;

    assign push             = drain;
    assign freespace_update = drain;    // credit leaves with the push
    assign clr_even         = drain && !sel_odd;
    assign clr_odd          = drain && sel_odd;

    //////////////////////////////////////////////////////////////////////
    // FSM and pointer
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            state     <= seq_issue;
            drain_ptr <= '0;
        end else begin
            case (state)
                seq_issue: begin
                    state <= seq_check;         // read in flight
                end
                seq_check: begin
                    state <= seq_issue;         // retry same slot if not drained
                    if (drain) begin
                        drain_ptr <= drain_ptr + 1'b1;  // wraps after 127
                    end
                end
                default: begin
                    state <= seq_issue;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/reorder_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_bank (
    input  wire                             clk_user,
    input  wire                             reset_user,
    input  wire                             wr_en,       // already bank-qualified
    input  wire input_port_pkg::bank_addr_t wr_addr,
    input  wire input_port_pkg::payload_t   wr_payload,
    input  wire input_port_pkg::bank_addr_t rd_addr,
    input  wire                             clr_en,      // drop flag at rd_addr
    output logic                            rd_flag,
    output input_port_pkg::payload_t        rd_payload
);
    import input_port_pkg::*;

    localparam int BANK_DEPTH = 1 << BANK_ADDR_BITS;  // 64 slots

    payload_t               slot_mem [BANK_DEPTH];
    logic [BANK_DEPTH-1:0]  slot_full;                // filled flags

    // write port
    always_ff @(posedge clk_user) begin
        if (wr_en) slot_mem[wr_addr] <= wr_payload;
    end

    // flags, clear first so a same-cycle write wins
    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            slot_full <= '0;
        end else begin
            if (clr_en) slot_full[rd_addr] <= 1'b0;
            if (wr_en)  slot_full[wr_addr] <= 1'b1;
        end
    end

    // read port, one cycle latency, read-first
    always_ff @(posedge clk_user) begin
        if (reset_user) rd_flag <= 1'b0;
        else            rd_flag <= slot_full[rd_addr];
    end

    always_ff @(posedge clk_user) begin
        rd_payload <= slot_mem[rd_addr];
    end

endmodule

`default_nettype wire

/* hw/width_converter.sv */
`timescale 1ns/1ps
`default_nettype none

module width_converter #(
    parameter int fifo_depth = 8           // 64-bit words held
) (
    input  wire                           clk_user,
    input  wire                           reset_user,
    input  wire                           push,
    input  wire input_port_pkg::payload_t push_payload,
    input  wire                           ack_user,
    output logic                          fifo_full,
    output logic                          fifo_empty,
    output input_port_pkg::user_word_t    dout_user,
    output logic                          vld_user
);
    import input_port_pkg::*;

    localparam int PTR_BITS = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int CNT_BITS = $clog2(fifo_depth + 1);

    payload_t            fifo_mem [fifo_depth];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] word_cnt;   // 64-bit words stored
    logic                half_hi;    // next half to hand out
    logic                wr_go;
    logic                load;       // take a half into dout_user
    logic                pop;        // last half of the head word taken

    assign fifo_full  = (word_cnt == CNT_BITS'(fifo_depth));
    assign fifo_empty = (word_cnt == '0);

    assign wr_go = push && !fifo_full;

    // load rule: data waiting and the output slot is free or being taken
    assign load = !fifo_empty && (ack_user || !vld_user);
    assign pop  = load && half_hi;

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_user) begin
        if (wr_go) fifo_mem[wr_ptr] <= push_payload;
    end

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            word_cnt <= '0;
            half_hi  <= 1'b0;
        end else begin
            if (wr_go) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (load) half_hi <= !half_hi;   // low, high, low ...
            case ({wr_go, pop})
                2'b10:   word_cnt <= word_cnt + 1'b1;
                2'b01:   word_cnt <= word_cnt - 1'b1;
                default: word_cnt <= word_cnt;   // both or neither
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // user side
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_user) begin
        if (load) begin
            dout_user <= half_hi ? fifo_mem[rd_ptr][USER_BITS +: USER_BITS]
                                 : fifo_mem[rd_ptr][0 +: USER_BITS];
        end
    end

    always_ff @(posedge clk_user) begin
        if (reset_user) begin
            vld_user <= 1'b0;
        end else if (load) begin
            vld_user <= 1'b1;
        end else if (ack_user) begin
            vld_user <= 1'b0;       // taken, nothing behind it
        end
    end

endmodule

`default_nettype wire

/* input_port.f */
hw/input_port_pkg.sv
hw/packet_decoder.sv
hw/reorder_bank.sv
hw/read_sequencer.sv
hw/width_converter.sv
hw/port_counters.sv
hw/input_port.sv
verif/input_port_sva.sv
verif/input_port_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the input_port testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module input_port_tb \
    -f input_port.f -o input_port_sim &&
./obj_dir/input_port_sim ||
exit 1

/* verif/input_port_sva.sv */
`timescale 1ns/1ps
`default_nettype none

// handshakes between the drain sequencer, the converter and the user
module input_port_sva (
    input wire                             clk_user,
    input wire                             reset_user,
    input wire                             push,
    input wire                             fifo_full,
    input wire                             freespace_update,
    input wire input_port_pkg::user_word_t dout_user,
    input wire                             vld_user,
    input wire                             ack_user
);

    // offered word holds until taken
    a_dout_hold: assert property (@(posedge clk_user) disable iff (reset_user)
        vld_user && !ack_user |=> $stable(dout_user))
        else $error("dout_user changed while waiting for ack_user");

    a_no_push_full: assert property (@(posedge clk_user) disable iff (reset_user)
        !(push && fifo_full))
        else $error("push issued while the FIFO was full");

    a_credit_push: assert property (@(posedge clk_user) disable iff (reset_user)
        freespace_update == push)   // one credit per drained slot
        else $error("freespace_update and push out of step");

endmodule

bind input_port input_port_sva i_input_port_sva (
    .clk_user, .reset_user, .push, .fifo_full, .freespace_update,
    .dout_user, .vld_user, .ack_user
);

`default_nettype wire

/* verif/input_port_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module input_port_tb;
    import input_port_pkg::*;

    localparam int PORT_NO        = 2;
    localparam int N_PKT          = 400;
    localparam int N_BAD          = 100;           // about a quarter
    localparam int N_GOOD         = N_PKT - N_BAD;
    localparam int CREDITS        = 128;
    localparam int WINDOW         = 16;            // reorder reach of the sender
    localparam int TIMEOUT_CYCLES = N_PKT * 16 + 1000;

    logic       clk_user = 1'b0;
    logic       reset_user;
    packet_t    din_leaf;
    leaf_t      src_leaf;
    port_t      src_port;
    logic       ack_user;
    logic       done_mode;
    logic       freespace_update;
    packet_t    freespace_packet;
    user_word_t dout_user;
    logic       vld_user;
    count_t     full_cnt;
    count_t     empty_cnt;
    count_t     read_cnt;
    logic       stall;

    logic [31:0] rng = 32'h6913_6de6;
    bit          sent_seq [];                      // by sequence index
    payload_t    exp_payload [];
    int          next_seq;
    int          accepted_cnt;
    int          pulse_cnt;
    int          halves_seen;
    int          model_reads;
    int          cycle_cnt;
    int          good_left;
    int          bad_left;
    int          ack_left;
    int          seq;
    logic        ack_quiet;
    logic        prev_done;
    count_t      prev_full;
    count_t      prev_empty;
    count_t      prev_read;
    logic [31:0] r;

    always #2 clk_user = ~clk_user;

    input_port #(.port_no(PORT_NO), .fifo_depth(8)) i_input_port (.*);

    ////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // packs the fields msb first
    function automatic packet_t make_packet(input logic v, input leaf_t leaf, input port_t port,
                                            input logic [14:0] unused, input slot_addr_t addr,
                                            input payload_t payload);
        return {v, leaf, port, unused, addr, payload};
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input user_word_t exp_w,
                              input user_word_t act_w);
        if (act_w !== exp_w) begin
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp_w, act_w));
        end
    endtask

    task automatic check_count(input string name, input count_t exp_c, input count_t act_c);
        if (act_c !== exp_c) begin
            fail_run($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp_c, act_c));
        end
    endtask

    task automatic check_packet(input string name, input packet_t exp_p, input packet_t act_p);
        if (act_p !== exp_p) begin
            fail_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp_p, act_p));
        end
    endtask

    // random free slot in the window and within credit or -1
    function automatic int pick_slot(input logic [31:0] rv);
        int hi;
        int n_free;
        int sel;
        int pick;
        hi = next_seq + WINDOW;
        if (hi > N_GOOD) hi = N_GOOD;
        if (hi > pulse_cnt + CREDITS) hi = pulse_cnt + CREDITS;
        n_free = 0;
        pick = -1;
        for (int i = next_seq; i < hi; i++) begin
            if (!sent_seq[i]) n_free++;
        end
        if (n_free == 0) return -1;
        sel = int'(rv[15:0]) % n_free;
        for (int i = next_seq; i < hi; i++) begin
            if (!sent_seq[i]) begin
                if (sel == 0 && pick < 0) pick = i;
                sel--;
            end
        end
        return pick;
    endfunction

    task automatic send_good(input int s);
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] rv;
        lo = rand32();
        hi = rand32();
        rv = rand32();
        exp_payload[s] = {hi, lo};
        sent_seq[s]    = 1'b1;
        din_leaf = make_packet(1'b1, leaf_t'(rv[5:0]), port_t'(PORT_NO), rv[30:16],
                               slot_addr_t'(s), {hi, lo});   // unused bits random
        accepted_cnt++;
        good_left--;
        while (next_seq < N_GOOD && sent_seq[next_seq]) next_seq++;
    endtask

    // wrong port or clear valid bit takes no credit
    task automatic send_bad(input logic [31:0] rv);
        port_t p;
        p = port_t'(rv[11:8]);
        if (p == port_t'(PORT_NO)) p = p + 4'd1;
        if (rv[6]) din_leaf = make_packet(1'b1, leaf_t'(rv[5:0]), p, 15'd0,
                                          slot_addr_t'(rv[22:16]), {rand32(), rand32()});
        else din_leaf = make_packet(1'b0, leaf_t'(rv[5:0]), port_t'(PORT_NO), 15'd0,
                                    slot_addr_t'(rv[22:16]), {rand32(), rand32()});
        bad_left--;
    endtask

    // ack comes in stretches and some are long and quiet
    task automatic drive_user_side();
        logic [31:0] rv;
        rv = rand32();
        if (ack_left == 0) begin
            ack_quiet = (rv[2:0] == 3'd0);
            ack_left  = ack_quiet ? 30 + int'(rv[8:4]) : 8 + int'(rv[7:4]);
        end
        ack_left--;
        ack_user = !ack_quiet && rv[12];
        if (rv[19:16] == 4'd0) done_mode = !done_mode;   // done mode flips now and then
    endtask

    task automatic check_transfer();
        int s;
        user_word_t exp_w;
        s = halves_seen / 2;
        if (s >= N_GOOD || !sent_seq[s]) fail_run("user word delivered for a slot never sent");
        exp_w = (halves_seen % 2 == 1) ? exp_payload[s][63:32] : exp_payload[s][31:0];
        check_word("user word", exp_w, dout_user);
        halves_seen++;
    endtask

    ////////////////////////////////////////////////////////////////////////
    // monitors sample on the rising edge
    ////////////////////////////////////////////////////////////////////////
    always @(posedge clk_user) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles", cycle_cnt));
        end
    end

    always @(posedge clk_user) begin
        if (reset_user) begin
            prev_done = 1'b0;
        end else begin
            check_count("read count", count_t'(model_reads), read_cnt);  // trails by one edge
            if (vld_user && ack_user) begin
                if (!done_mode) model_reads++;
                check_transfer();
            end
            if (freespace_update) begin
                if (pulse_cnt >= accepted_cnt) fail_run("credit returned beyond accepted packets");
                check_packet("credit packet",
                             make_packet(1'b1, src_leaf, src_port, 15'd0, 7'd0, 64'd1),
                             freespace_packet);
                pulse_cnt++;
            end
            if (prev_done) begin              // stats frozen across a done cycle
                check_count("full count hold", prev_full, full_cnt);
                check_count("empty count hold", prev_empty, empty_cnt);
                check_count("read count hold", prev_read, read_cnt);
            end
            if (done_mode && stall) fail_run("stall went high during done mode");
            prev_done  = done_mode;
            prev_full  = full_cnt;
            prev_empty = empty_cnt;
            prev_read  = read_cnt;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // stimulus on the falling edge
    ////////////////////////////////////////////////////////////////////////
    initial begin
        sent_seq    = new[N_GOOD];
        exp_payload = new[N_GOOD];
        good_left   = N_GOOD;
        bad_left    = N_BAD;
        reset_user  = 1'b1;
        din_leaf    = '0;
        ack_user    = 1'b0;
        done_mode   = 1'b0;
        ack_quiet   = 1'b0;
        r           = rand32();
        src_leaf    = leaf_t'(r[5:0]);
        src_port    = port_t'(r[11:8]);
        repeat (4) @(negedge clk_user);
        reset_user = 1'b0;

        while (good_left + bad_left > 0) begin
            @(negedge clk_user);
            drive_user_side();
            r = rand32();
            if (r[3:0] < 4'd3) begin
                din_leaf = '0;                    // idle
            end else if (good_left == 0 || (bad_left > 0 && r[5:4] == 2'b00)) begin
                send_bad(r);
            end else begin
                seq = pick_slot(rand32());
                if (seq < 0) din_leaf = '0;       // out of credit
                else send_good(seq);
            end
        end
        @(negedge clk_user);
        din_leaf = '0;
        while (halves_seen < 2 * N_GOOD) begin
            @(negedge clk_user);
            drive_user_side();
        end

        // nothing more may show up
        done_mode = 1'b0;
        ack_user  = 1'b1;
        repeat (40) @(negedge clk_user);
        check_count("credit total", count_t'(accepted_cnt), count_t'(pulse_cnt));
        check_count("read count final", count_t'(model_reads), read_cnt);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
